//--- dv/cpuTb.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] SENTINEL = 32'h3f0;
    localparam logic [31:0] ERR_ADDR = 32'h1e0;
    localparam logic [31:0] VAL_A = 32'h9e37_79b9;
    // opcodes, routing, memory, branch, the first three again, bus error and retry
    localparam int TOTAL_INSNS = 38 + 11 + 11 + 13 + 60 + 6 + 6;
    localparam int WATCHDOG_CYCLES = TOTAL_INSNS * 20 + 9 * (RESET_CYCLES + 2) + 40;

    logic                   clk;
    logic                   reset;
    busReq_t                req;
    logic                   stb, cyc, ack, err, rty, halted;
    logic [`CPU_WORD_W-1:0] rdata;
    logic                   randomAck, errEn, useRetry;
    logic [1:0]             ackDelay;
    logic [31:0]            rngState;
    logic [31:0]            prog [$];
    int                     errors, checks;

    cpuCore dut (
        .clk      (clk),
        .reset    (reset),
        .req_o    (req),
        .stb_o    (stb),
        .cyc_o    (cyc),
        .ack_i    (ack),
        .rdata_i  (rdata),
        .err_i    (err),
        .rty_i    (rty),
        .halted_o (halted)
    );

    tbMemory memory (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req),
        .stb_i     (stb),
        .delay_i   (ackDelay),
        .errEn_i   (errEn),
        .retry_i   (useRetry),
        .errAddr_i (ERR_ADDR),
        .ack_o     (ack),
        .rdata_o   (rdata),
        .err_o     (err),
        .rty_o     (rty)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    always @(posedge clk) rngState <= xorshift(rngState);
    assign ackDelay = randomAck ? rngState[1:0] : 2'd0;

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return 32'h5a5a_0000 ^ a ^ (a << 16);
    endfunction

    function automatic logic [31:0] regInsn(input insnKind_t kind, input logic [1:0] dd,
        input logic [3:0] z, input logic [3:0] x, input logic [3:0] y, input aluOp_t op,
        input logic [11:0] imm);
        return {kind, dd, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] immInsn(input logic [1:0] dd, input logic [3:0] z,
        input logic [3:0] x, input logic [19:0] imm);
        return {kindImm20, dd, z, x, imm};
    endfunction

    function automatic logic [11:0] opImm(input int op);
        return 12'(op * 157 - 1000); // negative for the low opcodes
    endfunction

    function automatic logic [31:0] aluModel(input aluOp_t op, input logic [31:0] a,
        input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (op)
            opOr:    return a | b;
            opAnd:   return a & b;
            opXor:   return a ^ b;
            opSra:   return sa >>> b;
            opAdd:   return a + b;
            opMul:   return a * b;
            opEq:    return {32{a == b}};
            opLt:    return {32{sa < sb}};
            opOrn:   return a | ~b;
            opAndn:  return a & ~b;
            opPack:  return {a[19:0], b[11:0]};
            opSrl:   return a >> b;
            opSub:   return a - b;
            opShl:   return a << b;
            opBit:   return {32{a[b[4:0]]}};
            default: return {32{sa >= sb}};
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("error %s: expected %h, actual %h", name, expected, actual);
            end
    endtask

    task automatic checkWord(input string name, input logic [31:0] addr,
        input logic [31:0] expected);
        checkValue(name, expected, memory.mem[addr[9:0]]);
    endtask

    task automatic loadConst(input logic [3:0] z, input logic [31:0] value);
        prog.push_back(immInsn(2'b00, z, 4'd0, value[31:12]));
        prog.push_back(regInsn(kindXIY, 2'b00, z, z, 4'd0, opPack, value[11:0]));
    endtask

    task automatic addImm(input logic [3:0] z, input logic [11:0] imm);
        prog.push_back(regInsn(kindXYI, 2'b00, z, z, 4'd0, opAdd, imm));
    endtask

    task automatic finishProgram();
        prog.push_back(immInsn(2'b00, 4'd14, 4'd0, SENTINEL[19:0]));
        prog.push_back(regInsn(kindXYI, 2'b10, 4'd14, 4'd0, 4'd0, opOr, 12'h0));
    endtask

    task automatic runProgram(input string name, input bit expectHalt);
        int limit;
        bit done;
        limit = prog.size() * 20;
        done = 1'b0;
        reset <= 1'b1;
        for (int a = 0; a < 1024; a++) begin
            memory.mem[a] <= fillWord(a);
        end
        foreach (prog[i]) begin
            memory.mem[`CPU_RESET_VECTOR + i] <= prog[i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        checks++;
        assert (!stb && !cyc && !req.we && !halted)
            else begin
                errors++;
                $display("%s: bus outputs not idle during reset", name);
            end
        reset <= 1'b0;
        while (!stb && limit > 0) begin
            @(posedge clk);
            limit--;
        end
        checkValue({name, " first fetch"}, `CPU_RESET_VECTOR, req.addr);
        while (!done && limit > 0) begin
            @(posedge clk);
            limit--;
            done = expectHalt ? halted : (stb && ack && req.we && req.addr == SENTINEL);
        end
        checks++;
        assert (done)
            else begin
                errors++;
                $display("%s: program did not finish in time", name);
            end
    endtask

    task automatic opcodeTest();
        logic [11:0] imm;
        prog.delete();
        loadConst(4'd1, VAL_A);
        prog.push_back(immInsn(2'b00, 4'd2, 4'd0, 20'd7));
        prog.push_back(immInsn(2'b00, 4'd3, 4'd0, 20'h100));
        for (int op = 0; op < 16; op++) begin
            prog.push_back(regInsn(kindXYI, 2'b10, 4'd3, 4'd1, 4'd2, aluOp_t'(op), opImm(op)));
            addImm(4'd3, 12'd1);
        end
        finishProgram();
        runProgram("opcodes", 1'b0);
        for (int op = 0; op < 16; op++) begin
            imm = opImm(op);
            checkWord($sformatf("opcode %0d", op), 32'h100 + op,
                aluModel(aluOp_t'(op), VAL_A, 32'd7) + {{20{imm[11]}}, imm});
        end
    endtask

    task automatic routingTest();
        prog.delete();
        loadConst(4'd1, VAL_A);
        prog.push_back(immInsn(2'b00, 4'd2, 4'd0, 20'h01234));
        prog.push_back(immInsn(2'b00, 4'd3, 4'd0, 20'h140));
        prog.push_back(regInsn(kindXIY, 2'b10, 4'd3, 4'd1, 4'd2, opSub, 12'hed4)); // -300
        addImm(4'd3, 12'd1);
        prog.push_back(regInsn(kindIXY, 2'b10, 4'd3, 4'd1, 4'd2, opSub, 12'hffb)); // -5
        addImm(4'd3, 12'd1);
        prog.push_back(immInsn(2'b10, 4'd3, 4'd1, 20'h80123));
        finishProgram();
        runProgram("routing", 1'b0);
        checkWord("kindXIY", 32'h140, VAL_A - 32'hffff_fed4 + 32'h1234);
        checkWord("kindIXY", 32'h141, 32'hffff_fffb - VAL_A + 32'h1234);
        checkWord("kindImm20", 32'h142, VAL_A + 32'hfff8_0123);
    endtask

    task automatic memoryTest();
        prog.delete();
        loadConst(4'd1, VAL_A);
        prog.push_back(immInsn(2'b00, 4'd2, 4'd0, 20'h180));
        prog.push_back(regInsn(kindXYI, 2'b01, 4'd1, 4'd2, 4'd0, opOr, 12'd0));
        prog.push_back(regInsn(kindXYI, 2'b11, 4'd4, 4'd2, 4'd0, opOr, 12'd0));
        prog.push_back(regInsn(kindXYI, 2'b01, 4'd4, 4'd2, 4'd0, opAdd, 12'd1));
        prog.push_back(immInsn(2'b00, 4'd0, 4'd0, 20'h12345)); // r0 write
        prog.push_back(regInsn(kindXYI, 2'b11, 4'd0, 4'd2, 4'd0, opOr, 12'd0));
        prog.push_back(regInsn(kindXYI, 2'b01, 4'd0, 4'd2, 4'd0, opAdd, 12'd2));
        finishProgram();
        runProgram("memory", 1'b0);
        checkWord("store dd01", 32'h180, VAL_A);
        checkWord("load and store back", 32'h181, VAL_A);
        checkWord("register 0", 32'h182, 32'h0);
    endtask

    task automatic branchTest();
        prog.delete();
        prog.push_back(immInsn(2'b00, 4'd3, 4'd0, 20'h1c0));
        prog.push_back(immInsn(2'b00, 4'd4, 4'd0, 20'h1c8));
        prog.push_back(regInsn(kindXYI, 2'b10, 4'd3, 4'd15, 4'd0, opOr, 12'd0));
        addImm(4'd3, 12'd1);
        prog.push_back(immInsn(2'b00, 4'd15, 4'd15, 20'd2)); // skip two
        prog.push_back(immInsn(2'b10, 4'd4, 4'd0, 20'h111));
        addImm(4'd3, 12'd5);
        prog.push_back(regInsn(kindXYI, 2'b10, 4'd3, 4'd15, 4'd0, opOr, 12'd0));
        prog.push_back(immInsn(2'b00, 4'd15, 4'd0, 20'(`CPU_RESET_VECTOR + 11)));
        prog.push_back(immInsn(2'b10, 4'd4, 4'd0, 20'h222));
        addImm(4'd3, 12'd5);
        finishProgram();
        runProgram("branch", 1'b0);
        checkWord("pc read", 32'h1c0, `CPU_RESET_VECTOR + 3);
        checkWord("pc after branch", 32'h1c1, `CPU_RESET_VECTOR + 8);
        checkWord("skipped add", 32'h1c6, fillWord(32'h1c6));
        checkWord("skipped store", 32'h1c8, fillWord(32'h1c8));
    endtask

    task automatic busErrorTest(input bit retry);
        string name;
        name = retry ? "bus retry" : "bus error";
        prog.delete();
        prog.push_back(immInsn(2'b00, 4'd3, 4'd0, ERR_ADDR[19:0]));
        prog.push_back(regInsn(kindXYI, 2'b10, 4'd3, 4'd0, 4'd0, opOr, 12'h5a5));
        addImm(4'd3, 12'd1);
        prog.push_back(regInsn(kindXYI, 2'b10, 4'd3, 4'd0, 4'd0, opOr, 12'h5a6));
        finishProgram();
        errEn <= 1'b1;
        useRetry <= retry;
        runProgram(name, 1'b1);
        repeat (20) @(posedge clk);
        checks++;
        assert (halted && !stb)
            else begin
                errors++;
                $display("%s did not leave the core halted and idle", name);
            end
        checkWord({name, " faulted store"}, ERR_ADDR, fillWord(ERR_ADDR));
        checkWord({name, " store after halt"}, ERR_ADDR + 1, fillWord(ERR_ADDR + 1));
        checkWord({name, " sentinel after halt"}, SENTINEL, fillWord(SENTINEL));
        errEn <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 8);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset <= 1'b1;
        randomAck <= 1'b0;
        errEn <= 1'b0;
        useRetry <= 1'b0;
        rngState <= 32'hc30e_e6c7;
        errors = 0;
        checks = 0;
        opcodeTest();
        routingTest();
        memoryTest();
        branchTest();
        randomAck <= 1'b1; // same programs under back-pressure
        opcodeTest();
        routingTest();
        memoryTest();
        busErrorTest(1'b0);
        busErrorTest(1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/tbMemory.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module tbMemory import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  busReq_t                req_i,
    input  logic                   stb_i,
    input  logic [1:0]             delay_i,
    input  logic                   errEn_i,
    input  logic                   retry_i,
    input  logic [`CPU_WORD_W-1:0] errAddr_i,
    output logic                   ack_o,
    output logic [`CPU_WORD_W-1:0] rdata_o,
    output logic                   err_o,
    output logic                   rty_o
);

    logic [`CPU_WORD_W-1:0] mem [0:1023];
    logic                   busy;
    logic [1:0]             waitCnt;
    logic                   ready;

    // response goes out this cycle
    assign ready = busy ? (waitCnt == 2'd0) : (delay_i == 2'd0);

    initial begin
        ack_o   <= 1'b0;
        rdata_o <= '0;
        err_o   <= 1'b0;
        rty_o   <= 1'b0;
        busy    <= 1'b0;
        waitCnt <= '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            rty_o <= 1'b0;
            busy  <= 1'b0;
        end else begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            rty_o <= 1'b0;
            if (stb_i && !ack_o && !err_o && !rty_o) begin // no second response to one request
                if (!ready) begin
                    busy    <= 1'b1;
                    waitCnt <= busy ? waitCnt - 2'd1 : delay_i - 2'd1;
                end else begin
                    busy <= 1'b0;
                    if (errEn_i && req_i.addr == errAddr_i) begin
                        if (retry_i) begin
                            rty_o <= 1'b1;
                        end else begin
                            err_o <= 1'b1; // write dropped
                        end
                    end else begin
                        ack_o   <= 1'b1;
                        rdata_o <= mem[req_i.addr[9:0]];
                        if (req_i.we) begin
                            mem[req_i.addr[9:0]] <= req_i.wdata;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- hdl/cpuCore.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output busReq_t                req_o,
    output logic                   stb_o,
    output logic                   cyc_o,
    input  logic                   ack_i,
    input  logic [`CPU_WORD_W-1:0] rdata_i,
    input  logic                   err_i,
    input  logic                   rty_i,
    output logic                   halted_o
);

    seqState_t              state;
    decodedInsn_t           dec;
    logic [`CPU_WORD_W-1:0] pc;       // current fetch address
    logic [`CPU_WORD_W-1:0] nextPc;
    logic [`CPU_WORD_W-1:0] insn;
    logic [`CPU_WORD_W-1:0] busData;
    logic [`CPU_WORD_W-1:0] resultQ;
    logic [`CPU_WORD_W-1:0] xVal, yVal, zVal;
    logic [`CPU_WORD_W-1:0] aVal, bVal, cVal;
    logic [`CPU_WORD_W-1:0] result;
    logic [`CPU_WORD_W-1:0] wrData, dataAddr, storeData, fetchAddr;
    logic                   execStart, execDone, wrEn, memOp, busFault;

    function automatic busReq_t makeReq(
        input logic [`CPU_WORD_W-1:0] addr,
        input logic [`CPU_WORD_W-1:0] wdata,
        input logic                   we
    );
        busReq_t req;
        req.addr  = addr;
        req.wdata = wdata;
        req.we    = we;
        return req;
    endfunction

    assign execStart = (state == stExec);
    assign wrEn      = (state == stWrite) && !dec.isStore;
    assign memOp     = dec.isLoad || dec.isStore;
    assign busFault  = stb_o && (err_i || rty_i);
    assign cyc_o     = stb_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stFetch;
            stb_o    <= 1'b0;
            req_o    <= makeReq(`CPU_RESET_VECTOR, '0, 1'b0);
            pc       <= `CPU_RESET_VECTOR;
            halted_o <= 1'b0;
        end else if (!halted_o) begin
            if (busFault) begin
                halted_o <= 1'b1; // sticky until reset
                stb_o    <= 1'b0;
                req_o.we <= 1'b0;
            end else begin
                case (state)
                    stFetch: begin
                        if (!stb_o) begin // first fetch after reset
                            stb_o <= 1'b1;
                            req_o <= makeReq(pc, '0, 1'b0);
                        end else if (ack_i) begin
                            stb_o <= 1'b0;
                            state <= stLatch;
                        end
                    end
                    stLatch: state <= stExec;
                    stExec: state <= stExecWait;
                    stExecWait: begin
                        if (execDone) begin
                            state <= stAddr;
                        end
                    end
                    stAddr: begin
                        if (memOp) begin
                            stb_o <= 1'b1;
                            req_o <= makeReq(dataAddr, storeData, dec.isStore);
                            state <= stData;
                        end else begin
                            state <= stWrite;
                        end
                    end
                    stData: begin
                        if (ack_i) begin
                            stb_o    <= 1'b0;
                            req_o.we <= 1'b0;
                            state    <= stWrite;
                        end
                    end
                    stWrite: begin // writeback and next fetch
                        pc    <= fetchAddr;
                        stb_o <= 1'b1;
                        req_o <= makeReq(fetchAddr, '0, 1'b0);
                        state <= stFetch;
                    end
                    default: state <= stFetch;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stb_o && ack_i) begin
            busData <= rdata_i; // fetch word or load data
        end
        if (state == stLatch) begin
            insn   <= busData;
            nextPc <= pc + 1'b1;
        end
        if (execDone) begin
            resultQ <= result;
        end
    end

    regFile uRegFile (
        .clk      (clk),
        .reset    (reset),
        .xIdx_i   (dec.x),
        .yIdx_i   (dec.y),
        .zIdx_i   (dec.z),
        .wrEn_i   (wrEn),
        .wrData_i (wrData),
        .nextPc_i (nextPc),
        .xVal_o   (xVal),
        .yVal_o   (yVal),
        .zVal_o   (zVal)
    );

    insnDecode uDecode (
        .insn_i (insn),
        .xVal_i (xVal),
        .yVal_i (yVal),
        .dec_o  (dec),
        .aVal_o (aVal),
        .bVal_o (bVal),
        .cVal_o (cVal)
    );

    execUnit uExec (
        .clk      (clk),
        .reset    (reset),
        .start_i  (execStart),
        .op_i     (dec.op),
        .aVal_i   (aVal),
        .bVal_i   (bVal),
        .cVal_i   (cVal),
        .done_o   (execDone),
        .result_o (result)
    );

    resultSelect uResult (
        .dec_i       (dec),
        .result_i    (resultQ),
        .loadData_i  (busData),
        .zVal_i      (zVal),
        .nextPc_i    (nextPc),
        .wrData_o    (wrData),
        .dataAddr_o  (dataAddr),
        .storeData_o (storeData),
        .fetchAddr_o (fetchAddr)
    );

    assert property (@(posedge clk) disable iff (reset) halted_o |-> !stb_o)
        else $error("strobe raised after halt");

    // request held through back-pressure
    assert property (@(posedge clk) disable iff (reset)
        (stb_o && !ack_i && !err_i && !rty_i) |=> (stb_o && $stable(req_o)))
        else $error("request changed before acknowledge");

endmodule

//--- hdl/cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        opOr   = 4'h0,
        opAnd  = 4'h1,
        opXor  = 4'h2,
        opSra  = 4'h3,
        opAdd  = 4'h4,
        opMul  = 4'h5,
        opEq   = 4'h6,
        opLt   = 4'h7,
        opOrn  = 4'h8,
        opAndn = 4'h9,
        opPack = 4'ha,
        opSrl  = 4'hb,
        opSub  = 4'hc,
        opShl  = 4'hd,
        opBit  = 4'he,
        opGe   = 4'hf
    } aluOp_t;

    // operand routing, see insnDecode
    typedef enum logic [1:0] {
        kindXYI   = 2'b00,
        kindXIY   = 2'b01,
        kindIXY   = 2'b10,
        kindImm20 = 2'b11
    } insnKind_t;

    typedef enum logic [2:0] {
        stExec,
        stExecWait,
        stAddr,
        stData,
        stWrite,
        stFetch,
        stLatch
    } seqState_t;

    typedef struct packed {
        logic [3:0]             z;
        logic [3:0]             x;
        logic [3:0]             y;
        aluOp_t                 op;
        insnKind_t              kind;
        logic [`CPU_WORD_W-1:0] imm;      // sign-extended
        logic                   isStore;
        logic                   isLoad;
        logic                   derefRhs; // dd[0]
        logic                   isBranch;
    } decodedInsn_t;

    typedef struct packed {
        logic [`CPU_WORD_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] wdata;
        logic                   we;
    } busReq_t;

endpackage

//--- hdl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_WORD_W 32

// word address of the first fetch
`define CPU_RESET_VECTOR 32'h0000_0000

`endif

//--- hdl/execUnit.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module execUnit import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_i,
    input  aluOp_t                 op_i,
    input  logic [`CPU_WORD_W-1:0] aVal_i,
    input  logic [`CPU_WORD_W-1:0] bVal_i,
    input  logic [`CPU_WORD_W-1:0] cVal_i,
    output logic                   done_o,
    output logic [`CPU_WORD_W-1:0] result_o
);

    logic                   valid1;
    logic                   valid2;
    aluOp_t                 op1;
    logic [`CPU_WORD_W-1:0] a1;
    logic [`CPU_WORD_W-1:0] b1;
    logic [`CPU_WORD_W-1:0] c1;
    logic [`CPU_WORD_W-1:0] alu2;
    logic [`CPU_WORD_W-1:0] c2;

    function automatic logic [`CPU_WORD_W-1:0] aluEval(
        input aluOp_t                 op,
        input logic [`CPU_WORD_W-1:0] a,
        input logic [`CPU_WORD_W-1:0] b
    );
        logic [`CPU_WORD_W-1:0] res;
        logic [`CPU_WORD_W-1:0] shifted;
        shifted = a >> b;
        case (op)
            opOr:   res = a | b;
            opAnd:  res = a & b;
            opXor:  res = a ^ b;
            opSra:  res = $signed(a) >>> b;
            opAdd:  res = a + b;
            opMul:  res = a * b;
            opEq:   res = {`CPU_WORD_W{a == b}};
            opLt:   res = {`CPU_WORD_W{$signed(a) < $signed(b)}};
            opOrn:  res = a | ~b;
            opAndn: res = a & ~b;
            opPack: res = {a[19:0], b[11:0]};
            opSrl:  res = a >> b;
            opSub:  res = a - b;
            opShl:  res = a << b;
            opBit:  res = {`CPU_WORD_W{shifted[0]}}; // bit b of a
            opGe:   res = {`CPU_WORD_W{$signed(a) >= $signed(b)}};
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            done_o <= 1'b0;
        end else begin
            valid1 <= start_i;
            valid2 <= valid1;
            done_o <= valid2;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin // stage 1
            op1 <= op_i;
            a1  <= aVal_i;
            b1  <= bVal_i;
            c1  <= cVal_i;
        end
        if (valid1) begin // stage 2
            alu2 <= aluEval(op1, a1, b1);
            c2   <= c1;
        end
        if (valid2) begin
            result_o <= alu2 + c2;
        end
    end

endmodule

//--- hdl/insnDecode.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module insnDecode import cpuPkg::*; (
    input  logic [`CPU_WORD_W-1:0] insn_i,
    input  logic [`CPU_WORD_W-1:0] xVal_i,
    input  logic [`CPU_WORD_W-1:0] yVal_i,
    output decodedInsn_t           dec_o,
    output logic [`CPU_WORD_W-1:0] aVal_o,
    output logic [`CPU_WORD_W-1:0] bVal_o,
    output logic [`CPU_WORD_W-1:0] cVal_o
);

    insnKind_t  kind;
    logic [1:0] dd;

    assign kind = insnKind_t'(insn_i[31:30]);
    assign dd   = insn_i[29:28];

    always_comb begin
        dec_o.kind = kind;
        dec_o.z    = insn_i[27:24];
        dec_o.x    = insn_i[23:20];
        if (kind == kindImm20) begin
            dec_o.y   = 4'd0;
            dec_o.op  = opOr; // forced
            dec_o.imm = {{(`CPU_WORD_W-20){insn_i[19]}}, insn_i[19:0]};
        end else begin
            dec_o.y   = insn_i[19:16];
            dec_o.op  = aluOp_t'(insn_i[15:12]);
            dec_o.imm = {{(`CPU_WORD_W-12){insn_i[11]}}, insn_i[11:0]};
        end
        dec_o.isStore  = ^dd;  // dd 01 or 10
        dec_o.isLoad   = &dd;
        dec_o.derefRhs = dd[0];
        dec_o.isBranch = (&insn_i[27:24]) && !(^dd);
    end

    always_comb begin
        case (kind)
            kindXYI: begin
                aVal_o = xVal_i;
                bVal_o = yVal_i;
                cVal_o = dec_o.imm;
            end
            kindXIY: begin
                aVal_o = xVal_i;
                bVal_o = dec_o.imm;
                cVal_o = yVal_i;
            end
            kindIXY: begin
                aVal_o = dec_o.imm;
                bVal_o = xVal_i;
                cVal_o = yVal_i;
            end
            default: begin // kindImm20
                aVal_o = '0;
                bVal_o = xVal_i;
                cVal_o = dec_o.imm;
            end
        endcase
    end

endmodule

//--- hdl/regFile.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [3:0]             xIdx_i,
    input  logic [3:0]             yIdx_i,
    input  logic [3:0]             zIdx_i,
    input  logic                   wrEn_i,
    input  logic [`CPU_WORD_W-1:0] wrData_i,
    input  logic [`CPU_WORD_W-1:0] nextPc_i,
    output logic [`CPU_WORD_W-1:0] xVal_o,
    output logic [`CPU_WORD_W-1:0] yVal_o,
    output logic [`CPU_WORD_W-1:0] zVal_o
);

    logic [`CPU_WORD_W-1:0] regs [1:14];

    // r0 is zero, r15 is the pc
    assign xVal_o = (xIdx_i == 4'd0)  ? '0 :
                    (xIdx_i == 4'd15) ? nextPc_i : regs[xIdx_i];
    assign yVal_o = (yIdx_i == 4'd0)  ? '0 :
                    (yIdx_i == 4'd15) ? nextPc_i : regs[yIdx_i];
    assign zVal_o = (zIdx_i == 4'd0)  ? '0 :
                    (zIdx_i == 4'd15) ? nextPc_i : regs[zIdx_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && zIdx_i != 4'd0 && zIdx_i != 4'd15) begin
            regs[zIdx_i] <= wrData_i;
        end
    end

endmodule

//--- hdl/resultSelect.sv
`include "cpu_config.svh"
`timescale 1ns/1ps

module resultSelect import cpuPkg::*; (
    input  decodedInsn_t           dec_i,
    input  logic [`CPU_WORD_W-1:0] result_i,
    input  logic [`CPU_WORD_W-1:0] loadData_i,
    input  logic [`CPU_WORD_W-1:0] zVal_i,
    input  logic [`CPU_WORD_W-1:0] nextPc_i,
    output logic [`CPU_WORD_W-1:0] wrData_o,
    output logic [`CPU_WORD_W-1:0] dataAddr_o,
    output logic [`CPU_WORD_W-1:0] storeData_o,
    output logic [`CPU_WORD_W-1:0] fetchAddr_o
);

    always_comb begin
        if (dec_i.derefRhs && dec_i.isLoad) begin
            wrData_o = loadData_i;
        end else begin
            wrData_o = result_i;
        end

        // dd 01 and 11 address by the result, dd 10 by Z
        if (dec_i.derefRhs) begin
            dataAddr_o  = result_i;
            storeData_o = zVal_i;
        end else begin
            dataAddr_o  = zVal_i;
            storeData_o = result_i;
        end

        if (dec_i.isBranch) begin
            fetchAddr_o = wrData_o; // write to r15
        end else begin
            fetchAddr_o = nextPc_i;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# compile and run cpuTb with Verilator, pass only if the pass line shows up
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f tb.f -o simv

out=$(./obj_dir/simv)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'All checks passed'; then
    exit 0
fi
exit 1

//--- tb.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/insnDecode.sv
hdl/execUnit.sv
hdl/resultSelect.sv
hdl/cpuCore.sv
dv/tbMemory.sv
dv/cpuTb.sv
